//--- sata_pkg.sv
// SATA transmit definitions
package sata_pkg;

  // One 32-bit bus word
  typedef logic [31:0] dword_t;

  // Dword 0 of a Register H2D FIS, fis_type sits in byte 0 on the wire
  typedef struct packed {
    logic [7:0] features_lo;
    logic [7:0] command;
    // Bit 7 is C, low nibble is the port multiplier
    logic [7:0] flags;
    logic [7:0] fis_type;
  } fis_hdr_t;

  // Header fields on write, raw word on read
  typedef union packed {
    dword_t   raw;
    fis_hdr_t hdr;
  } fis_dword_t;

  // FIS type and flag values
  localparam logic [7:0] FIS_TYPE_REG_H2D = 8'h27;
  localparam logic [7:0] FIS_C_BIT        = 8'h80;

  // Register H2D FIS length in dwords
  localparam int unsigned FIS_DWORDS = 5;

  // Primitives, K28.3 in byte 0
  // SYNC  = K28.3 D21.4 D21.5 D21.5
  localparam dword_t PRIM_SYNC  = 32'hB5B5_957C;
  // SOF   = K28.3 D21.5 D23.1 D23.1
  localparam dword_t PRIM_SOF   = 32'h3737_B57C;
  // EOF   = K28.3 D21.5 D21.6 D21.6
  localparam dword_t PRIM_EOF   = 32'hD5D5_B57C;
  // HOLD  = K28.3 D10.5 D21.6 D21.6
  localparam dword_t PRIM_HOLD  = 32'hD5D5_AA7C;
  // HOLDA = K28.3 D10.5 D21.4 D21.4
  localparam dword_t PRIM_HOLDA = 32'h9595_AA7C;

  // Frame CRC seed and generator polynomial
  localparam dword_t CRC_INIT = 32'h5232_5032;
  localparam dword_t CRC_POLY = 32'h04C1_1DB7;

endpackage

//--- sata_h2d_fis_builder.sv
// Register H2D FIS builder
module sata_h2d_fis_builder (
  input  logic             clk,
  input  logic             rst_n,

  // User command
  input  logic             send_user_command_stb,
  input  logic [7:0]       hard_drive_command,
  input  logic [15:0]      user_features,
  input  logic [47:0]      sector_address,
  input  logic [15:0]      sector_count,
  input  logic [7:0]       device,
  output logic             sata_ready,

  // Buffer write side
  input  logic             full,
  output logic             wr_en,
  output sata_pkg::dword_t wr_data,
  output logic             wr_last
);
  import sata_pkg::*;

  logic        busy;
  logic [2:0]  word_cnt;
  logic        last_word;

  // Captured command fields
  logic [7:0]  command_q;
  logic [15:0] features_q;
  logic [47:0] lba_q;
  logic [15:0] count_q;
  logic [7:0]  device_q;

  fis_dword_t  hdr_word;

  assign last_word = (word_cnt == 3'(FIS_DWORDS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      word_cnt <= '0;
    end else if (!busy) begin
      if (send_user_command_stb) begin
        busy     <= 1'b1;
        word_cnt <= '0;
      end
    end else if (!full) begin
      // One dword leaves per cycle with room in the buffer
      if (last_word) begin
        busy     <= 1'b0;
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && send_user_command_stb) begin
      command_q  <= hard_drive_command;
      features_q <= user_features;
      lba_q      <= sector_address;
      count_q    <= sector_count;
      device_q   <= device;
    end
  end

  // Dword 0 through the header view
  always_comb begin
    hdr_word                 = '0;
    hdr_word.hdr.fis_type    = FIS_TYPE_REG_H2D;
    hdr_word.hdr.flags       = FIS_C_BIT;
    hdr_word.hdr.command     = command_q;
    hdr_word.hdr.features_lo = features_q[7:0];
  end

  always_comb begin
    case (word_cnt)
      3'd0:    wr_data = hdr_word.raw;
      3'd1:    wr_data = {device_q, lba_q[23:0]};
      3'd2:    wr_data = {features_q[15:8], lba_q[47:24]};
      3'd3:    wr_data = {16'h0000, count_q};
      default: wr_data = '0;
    endcase
  end

  assign wr_en      = busy & ~full;
  assign wr_last    = last_word;
  assign sata_ready = ~busy;

  // Ready returns only right after the closing dword is written
  a_ready_after_last: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(sata_ready) |-> $past(wr_en && wr_last)
  ) else $error("sata_ready rose without a completed FIS");

endmodule

//--- sata_tx_fifo.sv
// Transmit dword FIFO
module sata_tx_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,

  // Write side
  input  logic             wr_en,
  input  sata_pkg::dword_t wr_data,
  input  logic             wr_last,
  output logic             full,

  // Read side, head entry shown without a read
  input  logic             rd_en,
  output sata_pkg::dword_t rd_data,
  output logic             rd_last,
  output logic             empty
);
  import sata_pkg::*;

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  dword_t        mem_data [FIFO_DEPTH];
  logic          mem_last [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          wr_ok;
  logic          rd_ok;

  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      // Occupancy only moves when one side acts alone
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem_data[wr_ptr] <= wr_data;
      mem_last[wr_ptr] <= wr_last;
    end
  end

  assign rd_data = mem_data[rd_ptr];
  assign rd_last = mem_last[rd_ptr];
  assign full    = (count == CW'(FIFO_DEPTH));
  assign empty   = (count == '0);

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> !full
  ) else $error("FIFO write while full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) rd_en |-> !empty
  ) else $error("FIFO read while empty");

endmodule

//--- sata_link_tx.sv
// Link layer transmitter
module sata_link_tx (
  input  logic             clk,
  input  logic             rst_n,

  // FIFO read side
  input  sata_pkg::dword_t rd_data,
  input  logic             rd_last,
  input  logic             empty,
  output logic             rd_en,

  // Remote side asks to pause data
  input  logic             remote_hold,

  // Toward the PHY
  output sata_pkg::dword_t tx_dout,
  output logic             tx_isk
);
  import sata_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;
  localparam logic [1:0] ST_CRC  = 2'd2;
  localparam logic [1:0] ST_EOF  = 2'd3;

  logic [1:0] state;
  dword_t     crc;

  // CRC-32 over one dword, MSB first, no reflection
  function automatic dword_t crc32_step(input dword_t crc_in, input dword_t data);
    dword_t c;
    logic   fb;
    c = crc_in;
    for (int i = 31; i >= 0; i--) begin
      fb = c[31] ^ data[i];
      c  = {c[30:0], 1'b0};
      if (fb) begin
        c = c ^ CRC_POLY;
      end
    end
    return c;
  endfunction

  // Pop only when a data dword actually goes out
  assign rd_en = (state == ST_DATA) && !remote_hold && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      tx_dout <= PRIM_SYNC;
      tx_isk  <= 1'b1;
      crc     <= CRC_INIT;
    end else begin
      case (state)
        ST_IDLE: begin
          tx_isk <= 1'b1;
          // At least one SYNC since the last EOF before a new SOF
          if (!empty && tx_dout == PRIM_SYNC) begin
            tx_dout <= PRIM_SOF;
            crc     <= CRC_INIT;
            state   <= ST_DATA;
          end else begin
            tx_dout <= PRIM_SYNC;
          end
        end

        ST_DATA: begin
          if (remote_hold) begin
            tx_dout <= PRIM_HOLDA;
            tx_isk  <= 1'b1;
          end else if (empty) begin
            // Buffer ran dry mid frame
            tx_dout <= PRIM_HOLD;
            tx_isk  <= 1'b1;
          end else begin
            tx_dout <= rd_data;
            tx_isk  <= 1'b0;
            crc     <= crc32_step(crc, rd_data);
            if (rd_last) begin
              state <= ST_CRC;
            end
          end
        end

        ST_CRC: begin
          // Includes the last data dword
          tx_dout <= crc;
          tx_isk  <= 1'b0;
          state   <= ST_EOF;
        end

        default: begin
          tx_dout <= PRIM_EOF;
          tx_isk  <= 1'b1;
          state   <= ST_IDLE;
        end
      endcase
    end
  end

  // Only primitives leave the link between frames
  a_idle_is_primitive: assert property (
    @(posedge clk) disable iff (!rst_n) (state == ST_IDLE) |-> tx_isk
  ) else $error("Data dword on the wire while the link is idle");

endmodule

//--- sata_tx_stack.sv
// SATA host transmit stack
module sata_tx_stack #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,

  // User command
  input  logic             send_user_command_stb,
  input  logic [7:0]       hard_drive_command,
  input  logic [15:0]      user_features,
  input  logic [47:0]      sector_address,
  input  logic [15:0]      sector_count,
  input  logic [7:0]       device,
  output logic             sata_ready,

  // Remote flow control
  input  logic             remote_hold,

  // Platform transmit
  output sata_pkg::dword_t tx_dout,
  output logic             tx_isk
);
  import sata_pkg::*;

  // Builder to FIFO
  logic   wr_en;
  dword_t wr_data;
  logic   wr_last;
  logic   full;

  // FIFO to link
  dword_t rd_data;
  logic   rd_last;
  logic   empty;
  logic   rd_en;

  sata_h2d_fis_builder u_builder (
    .clk                  (clk),
    .rst_n                (rst_n),
    .send_user_command_stb(send_user_command_stb),
    .hard_drive_command   (hard_drive_command),
    .user_features        (user_features),
    .sector_address       (sector_address),
    .sector_count         (sector_count),
    .device               (device),
    .sata_ready           (sata_ready),
    .full                 (full),
    .wr_en                (wr_en),
    .wr_data              (wr_data),
    .wr_last              (wr_last)
  );

  sata_tx_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (wr_en),
    .wr_data(wr_data),
    .wr_last(wr_last),
    .full   (full),
    .rd_en  (rd_en),
    .rd_data(rd_data),
    .rd_last(rd_last),
    .empty  (empty)
  );

  sata_link_tx u_link (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_data    (rd_data),
    .rd_last    (rd_last),
    .empty      (empty),
    .rd_en      (rd_en),
    .remote_hold(remote_hold),
    .tx_dout    (tx_dout),
    .tx_isk     (tx_isk)
  );

endmodule

//--- tb_sata_checks.svh
// Testbench reference models and checks
`ifndef TB_SATA_CHECKS_SVH
`define TB_SATA_CHECKS_SVH

  // LCG step with the classic C library constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Expected Register H2D FIS dword k for table row r
  function automatic dword_t fis_word(input int r, input int k);
    dword_t w;
    case (k)
      0:       w = {t_feat[r][7:0], t_cmd[r], FIS_C_BIT, FIS_TYPE_REG_H2D};
      1:       w = {t_dev[r], t_lba[r][23:0]};
      2:       w = {t_feat[r][15:8], t_lba[r][47:24]};
      3:       w = {16'h0000, t_cnt[r]};
      default: w = '0;
    endcase
    return w;
  endfunction

  // Frame CRC over the expected FIS of row r
  function automatic dword_t crc_of_row(input int r);
    dword_t c;
    c = CRC_INIT;
    for (int w = 0; w < int'(FIS_DWORDS); w++) begin
      // Whole word folded in first, then one shift per bit
      c = c ^ exp_fis[r][w];
      for (int b = 0; b < 32; b++) begin
        if (c[31]) begin
          c = {c[30:0], 1'b0} ^ CRC_POLY;
        end else begin
          c = {c[30:0], 1'b0};
        end
      end
    end
    return c;
  endfunction

  task automatic check_dword(input string name, input dword_t expected,
                             input dword_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0d ns: %s expected %08h actual %08h",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0d ns: %s expected %b actual %b",
                                  $time, name, expected, actual));
    end
  endtask

`endif

//--- tb_sata_tx_stack.sv
// SATA transmit stack testbench
module tb_sata_tx_stack;
  timeunit 1ns;
  timeprecision 100ps;
  import sata_pkg::*;

  localparam int NROWS    = 7;
  localparam int MON_IDLE = 0;
  localparam int MON_DATA = 1;
  localparam int MON_CRC  = 2;
  localparam int MON_EOF  = 3;

  logic        clk;
  logic        rst_n;
  logic        send_user_command_stb;
  logic [7:0]  hard_drive_command;
  logic [15:0] user_features;
  logic [47:0] sector_address;
  logic [15:0] sector_count;
  logic [7:0]  device;
  logic        remote_hold;
  logic        sata_ready;
  dword_t      tx_dout;
  logic        tx_isk;

  // Command table, one row per frame
  logic [7:0]  t_cmd [NROWS];
  logic [15:0] t_feat [NROWS];
  logic [47:0] t_lba [NROWS];
  logic [15:0] t_cnt [NROWS];
  logic [7:0]  t_dev [NROWS];
  int          t_hold_off [NROWS];
  int          t_hold_len [NROWS];
  dword_t      exp_fis [NROWS][FIS_DWORDS];
  dword_t      exp_crc [NROWS];

  // Absolute hold windows in cycles
  int          win_start [NROWS];
  int          win_end [NROWS];

  int          cycle = 0;
  int          cycle_limit = 0;
  int          frames_done = 0;
  int          holda_seen = 0;
  int          mon_phase = MON_IDLE;
  int          mon_idx = 0;
  logic        hold_prev = 1'b0;
  dword_t      prev_dout = PRIM_SYNC;
  int unsigned lcg_state = 6661;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  `include "tb_sata_checks.svh"

  task automatic set_row(input int r, input logic [7:0] cmd, input logic [15:0] feat,
                         input logic [47:0] lba, input logic [15:0] cnt,
                         input logic [7:0] dev, input int off, input int len);
    t_cmd[r]      = cmd;
    t_feat[r]     = feat;
    t_lba[r]      = lba;
    t_cnt[r]      = cnt;
    t_dev[r]      = dev;
    t_hold_off[r] = off;
    t_hold_len[r] = len;
  endtask

  sata_tx_stack #(
    .FIFO_DEPTH(8)
  ) dut (
    .clk                  (clk),
    .rst_n                (rst_n),
    .send_user_command_stb(send_user_command_stb),
    .hard_drive_command   (hard_drive_command),
    .user_features        (user_features),
    .sector_address       (sector_address),
    .sector_count         (sector_count),
    .device               (device),
    .sata_ready           (sata_ready),
    .remote_hold          (remote_hold),
    .tx_dout              (tx_dout),
    .tx_isk               (tx_isk)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic        hold;
    int          row;
    int          hold_total;
    rst_n                 = 1'b0;
    send_user_command_stb = 1'b0;
    hard_drive_command    = '0;
    user_features         = '0;
    sector_address        = '0;
    sector_count          = '0;
    device                = '0;
    remote_hold           = 1'b0;

    set_row(0, 8'hEC, 16'h0000, 48'h0000_0000_0000, 16'h0000, 8'hA0, 0, 0);
    set_row(1, 8'h25, 16'h0000, 48'h0000_1234_5678, 16'h0010, 8'h40, 8, 3);
    // Long hold backs up the FIFO until the builder stalls
    set_row(2, 8'h35, 16'hAB03, 48'h8765_4321_0FED, 16'h0100, 8'h40, 2, 40);
    set_row(3, 8'hEF, 16'h0203, 48'h0000_0000_0046, 16'h0000, 8'h00, 0, 0);
    for (int r = 4; r < NROWS; r++) begin
      a = lcg_next();
      b = lcg_next();
      c = lcg_next();
      d = lcg_next();
      set_row(r, a[7:0], a[31:16], {b[15:0], c}, b[31:16], a[15:8],
              int'(d[2:0]), int'(d[6:4]));
    end
    hold_total = 0;
    for (int r = 0; r < NROWS; r++) begin
      for (int k = 0; k < int'(FIS_DWORDS); k++) begin
        exp_fis[r][k] = fis_word(r, k);
      end
      exp_crc[r] = crc_of_row(r);
      hold_total += t_hold_len[r];
    end
    cycle_limit = 60 * NROWS + hold_total + 50;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle line before any command
    repeat (6) begin
      @(negedge clk);
      check_bit("sata_ready", 1'b1, sata_ready);
    end

    row = 0;
    while (frames_done < NROWS) begin
      @(negedge clk);
      // An accepted strobe drops ready on the next cycle
      if (send_user_command_stb) begin
        check_bit("sata_ready", 1'b0, sata_ready);
      end
      if (row < NROWS && sata_ready) begin
        hard_drive_command    = t_cmd[row];
        user_features         = t_feat[row];
        sector_address        = t_lba[row];
        sector_count          = t_cnt[row];
        device                = t_dev[row];
        send_user_command_stb = 1'b1;
        win_start[row]        = cycle + t_hold_off[row];
        win_end[row]          = win_start[row] + t_hold_len[row];
        row++;
      end else begin
        send_user_command_stb = 1'b0;
      end
      hold = 1'b0;
      for (int r = 0; r < row; r++) begin
        if (cycle >= win_start[r] && cycle < win_end[r]) begin
          hold = 1'b1;
        end
      end
      remote_hold = hold;
    end
    remote_hold = 1'b0;
    repeat (4) @(negedge clk);

    if (holda_seen > 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_failure("No HOLDA appeared on the line, so the remote hold went untested");
    end
  end

  // Frame monitor, tx_dout seen here was registered on the previous edge
  always @(posedge clk) begin
    if (rst_n) begin
      case (mon_phase)
        MON_IDLE: begin
          if (tx_isk && tx_dout == PRIM_SOF) begin
            if (prev_dout != PRIM_SYNC) begin
              stop_with_failure("A new SOF came without a SYNC after the previous frame");
            end
            if (frames_done >= NROWS) begin
              stop_with_failure("A frame started with no command left to send");
            end
            mon_idx   = 0;
            mon_phase = MON_DATA;
          end else begin
            check_dword("tx_dout", PRIM_SYNC, tx_dout);
            check_bit("tx_isk", 1'b1, tx_isk);
          end
        end
        MON_DATA: begin
          if (hold_prev) begin
            check_dword("tx_dout", PRIM_HOLDA, tx_dout);
            check_bit("tx_isk", 1'b1, tx_isk);
            holda_seen++;
          end else if (!(tx_isk && tx_dout == PRIM_HOLD)) begin
            // HOLD from a buffer underrun carries no data
            check_bit("tx_isk", 1'b0, tx_isk);
            check_dword("tx_dout", exp_fis[frames_done][mon_idx], tx_dout);
            mon_idx++;
            if (mon_idx == int'(FIS_DWORDS)) begin
              mon_phase = MON_CRC;
            end
          end
        end
        MON_CRC: begin
          check_bit("tx_isk", 1'b0, tx_isk);
          check_dword("tx_dout", exp_crc[frames_done], tx_dout);
          mon_phase = MON_EOF;
        end
        default: begin
          check_dword("tx_dout", PRIM_EOF, tx_dout);
          check_bit("tx_isk", 1'b1, tx_isk);
          frames_done++;
          mon_phase = MON_IDLE;
        end
      endcase
      hold_prev = remote_hold;
      prev_dout = tx_dout;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle <= cycle + 1;
      if (cycle > cycle_limit) begin
        stop_with_failure($sformatf("Timeout after %0d cycles with %0d of %0d frames seen",
                                    cycle, frames_done, NROWS));
      end
    end
  end

endmodule

//--- project.f
+incdir+.
sata_pkg.sv
sata_h2d_fis_builder.sv
sata_tx_fifo.sv
sata_link_tx.sv
sata_tx_stack.sv
tb_sata_tx_stack.sv

//--- Makefile
SOURCES = sata_pkg.sv sata_h2d_fis_builder.sv sata_tx_fifo.sv sata_link_tx.sv \
          sata_tx_stack.sv tb_sata_tx_stack.sv tb_sata_checks.svh

.PHONY: run clean

run: obj_dir/Vtb_sata_tx_stack
	@out="$$(./obj_dir/Vtb_sata_tx_stack)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

obj_dir/Vtb_sata_tx_stack: project.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f project.f --top-module tb_sata_tx_stack

clean:
	rm -rf obj_dir
